//--- design/core_pkg.sv
package core_pkg;

    parameter int xlen = 64;

    // major opcodes used by the supported subset
    parameter logic [6:0] op_reg    = 7'b0110011;
    parameter logic [6:0] op_imm    = 7'b0010011;
    parameter logic [6:0] op_load   = 7'b0000011;
    parameter logic [6:0] op_store  = 7'b0100011;
    parameter logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_and = 2'd2,
        alu_or  = 2'd3
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_t;

    // an all-zero payload is a bubble in every stage
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     instruction;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] read_data1;
        logic [xlen-1:0] read_data2;
        logic [xlen-1:0] immediate;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        alu_op_t         alu_op;
        logic            alu_src;
        logic            mem_read;
        logic            mem_write;
        logic            reg_write;
        logic            branch;
        logic            invalid;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
        logic            mem_read;
        logic            mem_write;
        logic            reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [4:0]      rd;
        logic            reg_write;
    } mem_wb_t;

endpackage

//--- design/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit
    import core_pkg::*;
#(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          flush,
    input  logic [xlen-1:0]               branch_target,
    input  logic                          imem_write,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  logic [31:0]                   imem_data,
    output logic [xlen-1:0]               pc,
    output logic [31:0]                   instruction
);

    localparam int imem_aw = $clog2(IMEM_DEPTH);
    localparam logic [31:0] nop_word = 32'h0000_0013; // addi x0,x0,0

    logic [31:0] imem [IMEM_DEPTH];
    logic        pc_in_range;

    // program load only while the core is held in reset
    always_ff @(posedge clock) begin
        if (reset && imem_write) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (flush) begin
            pc <= branch_target; // taken beq from execute
        end else if (!stall) begin
            pc <= pc + xlen'(4);
        end
    end

    assign pc_in_range = (pc[xlen-1:2] < IMEM_DEPTH);

    // combinational read, fetched word is captured by IF/ID
    assign instruction = pc_in_range ? imem[pc[imem_aw+1:2]] : nop_word;

endmodule

//--- design/pipe_register.sv
`timescale 1ns/10ps

module pipe_register #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t data_in,
    output payload_t data_out
);

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            data_out <= '0; // bubble
        end else if (!stall) begin
            data_out <= data_in;
        end
    end

    // flush takes priority, but both together points at a control bug
    assert property (@(posedge clock) disable iff (reset) !(stall && flush))
        else $error("pipe_register: stall and flush high together");

endmodule

//--- design/instruction_decoder.sv
`timescale 1ns/10ps

module instruction_decoder
    import core_pkg::*;
(
    input  logic [31:0]     instruction,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output logic [xlen-1:0] immediate,
    output alu_op_t         alu_op,
    output logic            alu_src,
    output logic            mem_read,
    output logic            mem_write,
    output logic            reg_write,
    output logic            branch,
    output logic            invalid
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign rd     = instruction[11:7];

    always_comb begin
        immediate = '0;
        alu_op    = alu_add;
        alu_src   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        invalid   = 1'b0;
        case (opcode)
            op_reg: begin
                reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = alu_add;
                    {7'b0100000, 3'b000}: alu_op = alu_sub;
                    {7'b0000000, 3'b111}: alu_op = alu_and;
                    {7'b0000000, 3'b110}: alu_op = alu_or;
                    default: begin
                        reg_write = 1'b0;
                        invalid   = 1'b1;
                    end
                endcase
            end
            op_imm: begin
                immediate = {{(xlen-12){instruction[31]}}, instruction[31:20]};
                alu_src   = 1'b1;
                reg_write = (funct3 == 3'b000); // addi only
                invalid   = (funct3 != 3'b000);
            end
            op_load: begin
                immediate = {{(xlen-12){instruction[31]}}, instruction[31:20]};
                alu_src   = 1'b1;
                mem_read  = (funct3 == 3'b011); // ld
                reg_write = (funct3 == 3'b011);
                invalid   = (funct3 != 3'b011);
            end
            op_store: begin
                immediate = {{(xlen-12){instruction[31]}}, instruction[31:25],
                             instruction[11:7]};
                alu_src   = 1'b1;
                mem_write = (funct3 == 3'b011); // sd
                invalid   = (funct3 != 3'b011);
            end
            op_branch: begin
                // offset already in bytes
                immediate = {{(xlen-13){instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
                alu_op    = alu_sub;
                branch    = (funct3 == 3'b000); // beq
                invalid   = (funct3 != 3'b000);
            end
            default: invalid = (instruction != '0); // all-zero word is a bubble
        endcase
    end

endmodule

//--- design/register_file.sv
`timescale 1ns/10ps

module register_file
    import core_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic [4:0]      read_addr1,
    input  logic [4:0]      read_addr2,
    input  logic            write_enable,
    input  logic [4:0]      write_addr,
    input  logic [xlen-1:0] write_data,
    input  logic [4:0]      debug_addr,
    output logic [xlen-1:0] read_data1,
    output logic [xlen-1:0] read_data2,
    output logic [xlen-1:0] debug_data
);

    logic [xlen-1:0] registers [32];
    logic            write_live;

    assign write_live = write_enable && (write_addr != 5'd0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write_live) begin
            registers[write_addr] <= write_data;
        end
    end

    // same-cycle writeback passes straight to decode
    assign read_data1 = (write_live && write_addr == read_addr1) ? write_data
                                                                 : registers[read_addr1];
    assign read_data2 = (write_live && write_addr == read_addr2) ? write_data
                                                                 : registers[read_addr2];
    assign debug_data = registers[debug_addr];

endmodule

//--- design/alu.sv
`timescale 1ns/10ps

module alu
    import core_pkg::*;
(
    input  alu_op_t         operation,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            equal
);

    always_comb begin
        case (operation)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            default: result = '0;
        endcase
    end

    assign equal = (a == b); // beq condition

endmodule

//--- design/data_memory.sv
`timescale 1ns/10ps

module data_memory
    import core_pkg::*;
#(
    parameter int DMEM_DEPTH = 256
) (
    input  logic            clock,
    input  logic            read,
    input  logic            write,
    input  logic [xlen-1:0] address,
    input  logic [xlen-1:0] write_data,
    output logic [xlen-1:0] read_data
);

    localparam int dmem_aw = $clog2(DMEM_DEPTH);

    logic [xlen-1:0] memory [DMEM_DEPTH];
    logic [xlen-4:0] word_index;
    logic            in_range;

    assign word_index = address[xlen-1:3]; // doubleword index
    assign in_range   = (word_index < DMEM_DEPTH);

    always_ff @(posedge clock) begin
        if (write && in_range) begin
            memory[word_index[dmem_aw-1:0]] <= write_data;
        end
    end

    assign read_data = (read && in_range) ? memory[word_index[dmem_aw-1:0]] : '0;

    // one access per instruction in the memory stage
    assert property (@(posedge clock) !(read && write))
        else $error("data_memory: read and write in the same cycle");

endmodule

//--- design/pipeline_control.sv
`timescale 1ns/10ps

module pipeline_control
    import core_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic [4:0] id_rs1,
    input  logic [4:0] id_rs2,
    input  logic [4:0] ex_rs1,
    input  logic [4:0] ex_rs2,
    input  logic [4:0] ex_rd,
    input  logic       ex_mem_read,
    input  logic       ex_reg_write,
    input  logic [4:0] mem_rd,
    input  logic       mem_mem_read,
    input  logic       mem_reg_write,
    input  logic [4:0] wb_rd,
    input  logic       wb_reg_write,
    input  logic       branch_taken,
    output logic       stall,
    output logic       flush,
    output fwd_sel_t   forward_a,
    output fwd_sel_t   forward_b
);

    logic mem_can_forward;
    logic wb_can_forward;

    // load data is not ready until writeback
    assign mem_can_forward = mem_reg_write && !mem_mem_read && (mem_rd != 5'd0);
    assign wb_can_forward  = wb_reg_write && (wb_rd != 5'd0);

    function automatic fwd_sel_t select_source(input logic [4:0] source);
        if (mem_can_forward && mem_rd == source) begin
            return fwd_mem;
        end else if (wb_can_forward && wb_rd == source) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign forward_a = select_source(ex_rs1);
    assign forward_b = select_source(ex_rs2);

    // load in execute feeding the instruction in decode
    assign stall = ex_mem_read && ex_reg_write && (ex_rd != 5'd0)
                   && (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign flush = branch_taken;

    // a load in execute is never also the branch being resolved
    assert property (@(posedge clock) disable iff (reset) !(stall && flush))
        else $error("pipeline_control: stall and flush high together");

endmodule

//--- design/riscv_core.sv
`timescale 1ns/10ps

module riscv_core
    import core_pkg::*;
#(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          imem_write,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  logic [31:0]                   imem_data,
    input  logic [4:0]                    debug_addr,
    output logic [xlen-1:0]               debug_data,
    output logic                          retire_valid,
    output logic [4:0]                    retire_rd,
    output logic [xlen-1:0]               retire_value,
    output logic                          illegal_instruction
);

    if_id_t  if_id_d, if_id_q;
    id_ex_t  id_ex_d, id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    logic            stall, flush, branch_taken;
    fwd_sel_t        forward_a, forward_b;
    logic [xlen-1:0] fetch_pc, branch_target;
    logic [31:0]     fetch_instruction;

    logic [4:0]      dec_rs1, dec_rs2, dec_rd;
    logic [xlen-1:0] dec_immediate, reg_data1, reg_data2;
    alu_op_t         dec_alu_op;
    logic            dec_alu_src, dec_mem_read, dec_mem_write;
    logic            dec_reg_write, dec_branch, dec_invalid;

    logic [xlen-1:0] operand_a, forwarded_b, operand_b, alu_result, dmem_read_data;
    logic            alu_equal;

    function automatic logic [xlen-1:0] forward_mux(input fwd_sel_t sel,
                                                    input logic [xlen-1:0] reg_value,
                                                    input logic [xlen-1:0] mem_value,
                                                    input logic [xlen-1:0] wb_value);
        case (sel)
            fwd_mem: return mem_value;
            fwd_wb:  return wb_value;
            default: return reg_value;
        endcase
    endfunction

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clock(clock), .reset(reset), .stall(stall), .flush(flush),
        .branch_target(branch_target), .imem_write(imem_write),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .pc(fetch_pc), .instruction(fetch_instruction)
    );

    assign if_id_d = '{pc: fetch_pc, instruction: fetch_instruction};

    pipe_register #(.payload_t(if_id_t)) u_if_id (
        .clock(clock), .reset(reset), .stall(stall), .flush(flush),
        .data_in(if_id_d), .data_out(if_id_q)
    );

    instruction_decoder u_decoder (
        .instruction(if_id_q.instruction), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .immediate(dec_immediate), .alu_op(dec_alu_op), .alu_src(dec_alu_src),
        .mem_read(dec_mem_read), .mem_write(dec_mem_write), .reg_write(dec_reg_write),
        .branch(dec_branch), .invalid(dec_invalid)
    );

    register_file u_regs (
        .clock(clock), .reset(reset), .read_addr1(dec_rs1), .read_addr2(dec_rs2),
        .write_enable(mem_wb_q.reg_write), .write_addr(mem_wb_q.rd),
        .write_data(mem_wb_q.result), .debug_addr(debug_addr),
        .read_data1(reg_data1), .read_data2(reg_data2), .debug_data(debug_data)
    );

    assign id_ex_d = '{pc: if_id_q.pc, read_data1: reg_data1, read_data2: reg_data2,
                       immediate: dec_immediate, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd,
                       alu_op: dec_alu_op, alu_src: dec_alu_src, mem_read: dec_mem_read,
                       mem_write: dec_mem_write, reg_write: dec_reg_write,
                       branch: dec_branch, invalid: dec_invalid};

    // load-use stall inserts a bubble here while IF/ID holds
    pipe_register #(.payload_t(id_ex_t)) u_id_ex (
        .clock(clock), .reset(reset), .stall(1'b0), .flush(flush || stall),
        .data_in(id_ex_d), .data_out(id_ex_q)
    );

    pipeline_control u_control (
        .clock(clock), .reset(reset), .id_rs1(dec_rs1), .id_rs2(dec_rs2),
        .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2), .ex_rd(id_ex_q.rd),
        .ex_mem_read(id_ex_q.mem_read), .ex_reg_write(id_ex_q.reg_write),
        .mem_rd(ex_mem_q.rd), .mem_mem_read(ex_mem_q.mem_read),
        .mem_reg_write(ex_mem_q.reg_write), .wb_rd(mem_wb_q.rd),
        .wb_reg_write(mem_wb_q.reg_write), .branch_taken(branch_taken),
        .stall(stall), .flush(flush), .forward_a(forward_a), .forward_b(forward_b)
    );

    assign operand_a   = forward_mux(forward_a, id_ex_q.read_data1,
                                     ex_mem_q.alu_result, mem_wb_q.result);
    assign forwarded_b = forward_mux(forward_b, id_ex_q.read_data2,
                                     ex_mem_q.alu_result, mem_wb_q.result);
    assign operand_b   = id_ex_q.alu_src ? id_ex_q.immediate : forwarded_b;

    alu u_alu (
        .operation(id_ex_q.alu_op), .a(operand_a), .b(operand_b),
        .result(alu_result), .equal(alu_equal)
    );

    assign branch_taken  = id_ex_q.branch && alu_equal;
    assign branch_target = id_ex_q.pc + id_ex_q.immediate;
    assign illegal_instruction = id_ex_q.invalid;

    assign ex_mem_d = '{alu_result: alu_result, store_data: forwarded_b, rd: id_ex_q.rd,
                        mem_read: id_ex_q.mem_read, mem_write: id_ex_q.mem_write,
                        reg_write: id_ex_q.reg_write};

    pipe_register #(.payload_t(ex_mem_t)) u_ex_mem (
        .clock(clock), .reset(reset), .stall(1'b0), .flush(1'b0),
        .data_in(ex_mem_d), .data_out(ex_mem_q)
    );

    data_memory #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem (
        .clock(clock), .read(ex_mem_q.mem_read), .write(ex_mem_q.mem_write),
        .address(ex_mem_q.alu_result), .write_data(ex_mem_q.store_data),
        .read_data(dmem_read_data)
    );

    assign mem_wb_d = '{result: ex_mem_q.mem_read ? dmem_read_data : ex_mem_q.alu_result,
                        rd: ex_mem_q.rd, reg_write: ex_mem_q.reg_write};

    pipe_register #(.payload_t(mem_wb_t)) u_mem_wb (
        .clock(clock), .reset(reset), .stall(1'b0), .flush(1'b0),
        .data_in(mem_wb_d), .data_out(mem_wb_q)
    );

    assign retire_valid = mem_wb_q.reg_write && (mem_wb_q.rd != 5'd0);
    assign retire_rd    = mem_wb_q.rd;
    assign retire_value = mem_wb_q.result;

endmodule

//--- testbench/riscv_core_tb.sv
`timescale 1ns/10ps

module riscv_core_tb
    import core_pkg::*;
();

    localparam int imem_depth        = 64;
    localparam int imem_aw           = $clog2(imem_depth);
    localparam int dmem_depth        = 16;
    localparam int reset_cycles      = 3;
    localparam int drain_cycles      = 10;
    localparam int test_count        = 6;
    localparam int max_program_words = 16;
    // per test: reset, load, run, drain and 32 register reads
    localparam int timeout_cycles =
        3 * test_count * (reset_cycles + 3 * max_program_words + drain_cycles + 36);
    localparam logic [31:0] marker_word = 32'h0000_0063; // beq x0,x0,0
    localparam logic [31:0] nop_word    = 32'h0000_0013;

    logic                          clock;
    logic                          reset;
    logic                          imem_write;
    logic [$clog2(imem_depth)-1:0] imem_addr;
    logic [31:0]                   imem_data;
    logic [4:0]                    debug_addr;
    logic [xlen-1:0]               debug_data;
    logic                          retire_valid;
    logic [4:0]                    retire_rd;
    logic [xlen-1:0]               retire_value;
    logic                          illegal_instruction;

    integer          seed = 32'he977_1dd7;
    int              cycle_count;
    int              expected_illegal;
    logic [31:0]     prog_words[$];
    logic [xlen-1:0] ref_regs[32];
    logic [xlen-1:0] ref_mem[dmem_depth];
    logic [4:0]      expected_rd[$];
    logic [xlen-1:0] expected_value[$];
    logic [4:0]      retired_rd[$];
    logic [xlen-1:0] retired_value[$];
    logic            illegal_trace[$];

    riscv_core #(.IMEM_DEPTH(imem_depth), .DMEM_DEPTH(dmem_depth)) DUT (
        .clock(clock), .reset(reset), .imem_write(imem_write), .imem_addr(imem_addr),
        .imem_data(imem_data), .debug_addr(debug_addr), .debug_data(debug_data),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value),
        .illegal_instruction(illegal_instruction)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    // index n of illegal_trace is the state after the n-th edge out of reset
    always @(negedge clock) begin
        if (reset) begin
            illegal_trace.delete();
            retired_rd.delete();
            retired_value.delete();
        end else begin
            illegal_trace.push_back(illegal_instruction);
            if (retire_valid) begin
                retired_rd.push_back(retire_rd);
                retired_value.push_back(retire_value);
            end
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd, rs1, rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, rs1, rs2);
        return r_type(7'b0000000, 3'b000, rd, rs1, rs2);
    endfunction

    function automatic logic [31:0] sub_word(input logic [4:0] rd, rs1, rs2);
        return r_type(7'b0100000, 3'b000, rd, rs1, rs2);
    endfunction

    function automatic logic [31:0] and_word(input logic [4:0] rd, rs1, rs2);
        return r_type(7'b0000000, 3'b111, rd, rs1, rs2);
    endfunction

    function automatic logic [31:0] or_word(input logic [4:0] rd, rs1, rs2);
        return r_type(7'b0000000, 3'b110, rd, rs1, rs2);
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] ld_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sd_word(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_word(input logic [4:0] rs1, rs2,
                                             input logic [12:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, 3'b000, offset[4:1], offset[11],
                7'b1100011};
    endfunction

    function automatic logic [11:0] random_imm();
        return 12'($random(seed));
    endfunction

    function automatic void commit_write(input logic [4:0] rd, input logic [xlen-1:0] value);
        if (rd != 5'd0) begin
            ref_regs[rd] = value;
            expected_rd.push_back(rd);
            expected_value.push_back(value);
        end
    endfunction

    task automatic check_value(input string what, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // sequential ISA model, runs until it reaches the self-loop marker
    task automatic run_reference();
        int              pc;
        int              steps;
        logic [31:0]     word;
        logic [xlen-1:0] a, b, imm_i, imm_s, imm_b, addr;
        pc = 0;
        steps = 0;
        expected_illegal = 0;
        expected_rd.delete();
        expected_value.delete();
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        word = prog_words[0];
        while (word != marker_word && steps < 4 * max_program_words) begin
            a     = ref_regs[word[19:15]];
            b     = ref_regs[word[24:20]];
            imm_i = {{(xlen-12){word[31]}}, word[31:20]};
            imm_s = {{(xlen-12){word[31]}}, word[31:25], word[11:7]};
            imm_b = {{(xlen-13){word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            pc    = pc + 4;
            casez ({word[31:25], word[14:12], word[6:0]})
                17'b0000000_000_0110011: commit_write(word[11:7], a + b);
                17'b0100000_000_0110011: commit_write(word[11:7], a - b);
                17'b0000000_111_0110011: commit_write(word[11:7], a & b);
                17'b0000000_110_0110011: commit_write(word[11:7], a | b);
                17'b???????_000_0010011: commit_write(word[11:7], a + imm_i);
                17'b???????_011_0000011: begin
                    addr = a + imm_i;
                    commit_write(word[11:7], (addr >> 3) < dmem_depth ? ref_mem[addr >> 3] : '0);
                end
                17'b???????_011_0100011: begin
                    addr = a + imm_s;
                    if ((addr >> 3) < dmem_depth) begin
                        ref_mem[addr >> 3] = b;
                    end
                end
                17'b???????_000_1100011: begin
                    if (a == b) begin
                        pc = pc - 4 + int'($signed(imm_b));
                    end
                end
                default: begin
                    expected_illegal++; // invalid word, no state change
                end
            endcase
            steps++;
            word = prog_words[pc / 4];
        end
    endtask

    task automatic load_program();
        @(posedge clock);
        reset      <= 1'b1;
        imem_write <= 1'b0;
        repeat (reset_cycles - 1) @(posedge clock);
        foreach (prog_words[i]) begin
            @(posedge clock);
            imem_write <= 1'b1;
            imem_addr  <= imem_aw'(i);
            imem_data  <= prog_words[i];
        end
        @(posedge clock);
        imem_write <= 1'b0;
        reset      <= 1'b0;
    endtask

    task automatic run_program(input string name);
        int marker_addr;
        int illegal_pulses;
        marker_addr = 4 * prog_words.size();
        illegal_pulses = 0;
        prog_words.push_back(marker_word);
        prog_words.push_back(nop_word); // fetched behind the self-loop, always flushed
        prog_words.push_back(nop_word);
        run_reference();
        load_program();
        @(negedge clock);
        while (DUT.fetch_pc !== xlen'(marker_addr)) begin
            @(negedge clock);
        end
        repeat (drain_cycles) @(posedge clock);
        for (int r = 0; r < 32; r++) begin
            @(posedge clock);
            debug_addr <= 5'(r);
            @(negedge clock);
            check_value($sformatf("%s: x%0d", name, r), debug_data, ref_regs[r]);
        end
        check_value($sformatf("%s: retire count", name), retired_rd.size(), expected_rd.size());
        foreach (expected_rd[i]) begin
            check_value($sformatf("%s: retire %0d rd", name, i), retired_rd[i], expected_rd[i]);
            check_value($sformatf("%s: retire %0d value", name, i), retired_value[i],
                        expected_value[i]);
        end
        foreach (illegal_trace[i]) begin
            illegal_pulses += illegal_trace[i];
        end
        check_value($sformatf("%s: illegal pulses", name), illegal_pulses, expected_illegal);
    endtask

    task automatic alu_forwarding();
        prog_words.delete();
        prog_words.push_back(addi_word(1, 0, random_imm()));
        prog_words.push_back(addi_word(2, 0, random_imm()));
        prog_words.push_back(add_word(3, 1, 2)); // x1 from writeback, x2 from memory
        prog_words.push_back(sub_word(4, 3, 1));
        prog_words.push_back(and_word(5, 4, 3));
        prog_words.push_back(or_word(6, 5, 2));
        prog_words.push_back(addi_word(7, 6, random_imm()));
        prog_words.push_back(sub_word(8, 7, 7));
        prog_words.push_back(or_word(9, 1, 7));
        run_program("alu forwarding");
    endtask

    task automatic store_then_load();
        prog_words.delete();
        prog_words.push_back(addi_word(1, 0, random_imm()));
        prog_words.push_back(addi_word(2, 0, 12'd16));
        prog_words.push_back(sd_word(1, 2, 12'd8));
        prog_words.push_back(ld_word(3, 2, 12'd8));
        prog_words.push_back(add_word(4, 3, 1)); // load-use stall
        prog_words.push_back(addi_word(5, 0, random_imm()));
        prog_words.push_back(sd_word(5, 2, 12'd0));
        prog_words.push_back(ld_word(6, 2, 12'd0));
        prog_words.push_back(add_word(7, 6, 6));
        prog_words.push_back(add_word(8, 4, 7));
        run_program("store then load");
    endtask

    task automatic branch_skipping();
        prog_words.delete();
        prog_words.push_back(addi_word(1, 0, 12'd5));
        prog_words.push_back(addi_word(2, 0, 12'd5));
        prog_words.push_back(beq_word(1, 2, 13'd12)); // taken
        prog_words.push_back(addi_word(3, 0, 12'd111));
        prog_words.push_back(addi_word(4, 0, 12'd222));
        prog_words.push_back(addi_word(5, 0, 12'd33));
        prog_words.push_back(addi_word(6, 0, 12'd7));
        prog_words.push_back(beq_word(5, 6, 13'd12)); // not taken
        prog_words.push_back(addi_word(7, 0, 12'd44));
        prog_words.push_back(addi_word(8, 0, 12'd55));
        run_program("branch");
    endtask

    task automatic zero_register_writes();
        prog_words.delete();
        prog_words.push_back(addi_word(0, 0, random_imm() | 12'h001));
        prog_words.push_back(add_word(1, 0, 0));
        prog_words.push_back(addi_word(2, 0, random_imm()));
        prog_words.push_back(add_word(0, 2, 2));
        prog_words.push_back(or_word(3, 0, 2));
        prog_words.push_back(sub_word(4, 2, 0));
        prog_words.push_back(addi_word(0, 2, 12'd5));
        prog_words.push_back(and_word(5, 0, 2));
        run_program("x0 writes");
    endtask

    task automatic out_of_range_access();
        prog_words.delete();
        prog_words.push_back(addi_word(1, 0, random_imm() | 12'h001));
        prog_words.push_back(sd_word(1, 0, 12'd1024)); // beyond the data memory
        prog_words.push_back(ld_word(2, 0, 12'd1024));
        prog_words.push_back(sd_word(1, 0, 12'hff8)); // wraps to a huge address
        prog_words.push_back(ld_word(3, 0, 12'hff8));
        prog_words.push_back(add_word(4, 3, 1));
        prog_words.push_back(sd_word(1, 0, 12'd8));
        prog_words.push_back(ld_word(5, 0, 12'd8));
        run_program("out of range");
    endtask

    task automatic invalid_opcode();
        int invalid_index;
        invalid_index = 2;
        prog_words.delete();
        prog_words.push_back(addi_word(1, 0, random_imm()));
        prog_words.push_back(addi_word(2, 0, random_imm()));
        prog_words.push_back(r_type(7'b0000001, 3'b000, 5'd5, 5'd1, 5'd2)); // mul
        prog_words.push_back(add_word(3, 1, 2));
        prog_words.push_back(or_word(4, 3, 1));
        run_program("invalid opcode");
        // one word per edge, so the invalid word sits in ID/EX after edge index+2
        check_value("invalid opcode: flag before", illegal_trace[invalid_index + 1], 1'b0);
        check_value("invalid opcode: flag pulse", illegal_trace[invalid_index + 2], 1'b1);
        check_value("invalid opcode: flag after", illegal_trace[invalid_index + 3], 1'b0);
    endtask

    initial begin
        reset      = 1'b1;
        imem_write = 1'b0;
        imem_addr  = '0;
        imem_data  = '0;
        debug_addr = '0;
        repeat (reset_cycles) @(posedge clock);
        alu_forwarding();
        store_then_load();
        branch_skipping();
        zero_register_writes();
        out_of_range_access();
        invalid_opcode();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- riscv_core.f
design/core_pkg.sv
design/fetch_unit.sv
design/pipe_register.sv
design/instruction_decoder.sv
design/register_file.sv
design/alu.sv
design/data_memory.sv
design/pipeline_control.sv
design/riscv_core.sv
testbench/riscv_core_tb.sv
